// File: Makefile
# Verilator build and run for the memory subsystem testbench

SIM      ?= verilator
TOP      ?= tb_mem_sys
FILELIST ?= sources.f
BUILD    ?= obj_dir
LOG      ?= sim.log
SEED     ?= 9
VFLAGS   ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run, and scan $(LOG) for the result"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: SIM TOP FILELIST BUILD LOG SEED VFLAGS"

test:
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; true
	@cat $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF '** PASS **' $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)

// File: common/mem_sys_pkg.sv
package mem_sys_pkg;

    // bus word and byte-enable widths
    localparam int unsigned BUS_DATA_WIDTH = 32;
    localparam int unsigned BUS_BE_WIDTH   = 4;

    // ram decodes 14 byte-address bits, 16 KiB
    localparam int unsigned RAM_ADDR_WIDTH = 14;
    localparam int unsigned RAM_WORDS      = 2 ** (RAM_ADDR_WIDTH - 2);

    // everything at or above this is a peripheral access
    localparam logic [BUS_DATA_WIDTH-1:0] PERIPH_BASE = 32'h1000_0000;

    // character output
    localparam logic [BUS_DATA_WIDTH-1:0] PRINT_ADDR = 32'h1000_0000;

    // timer counter, compare and software interrupt
    localparam logic [BUS_DATA_WIDTH-1:0] TIMER_VALUE_ADDR = 32'h1500_0000;
    localparam logic [BUS_DATA_WIDTH-1:0] TIMER_CMP_ADDR   = 32'h1500_0004;
    localparam logic [BUS_DATA_WIDTH-1:0] SW_IRQ_ADDR      = 32'h1500_0008;

    // test control
    localparam logic [BUS_DATA_WIDTH-1:0] TEST_STATUS_ADDR = 32'h2000_0000;
    localparam logic [BUS_DATA_WIDTH-1:0] EXIT_ADDR        = 32'h2000_0004;

    // writing this to the status register means pass, anything else fail
    localparam logic [BUS_DATA_WIDTH-1:0] PASS_MAGIC = 32'd123456789;

    // interrupt ids as they come back with the acknowledge
    localparam int unsigned IRQ_ID_WIDTH = 5;
    localparam logic [IRQ_ID_WIDTH-1:0] IRQ_ID_SW    = 5'd3;
    localparam logic [IRQ_ID_WIDTH-1:0] IRQ_ID_TIMER = 5'd7;

endpackage

// File: common/obi_if.sv
`timescale 1ns/1ps

interface obi_if;

    import mem_sys_pkg::*;

    // request side, driven by the master
    logic                      req;
    logic [BUS_DATA_WIDTH-1:0] addr;
    logic                      we;
    logic [BUS_BE_WIDTH-1:0]   be;
    logic [BUS_DATA_WIDTH-1:0] wdata;

    // response side, driven by the slave
    logic                      gnt;
    logic                      rvalid;
    logic [BUS_DATA_WIDTH-1:0] rdata;

    modport master (
        output req,
        output addr,
        output we,
        output be,
        output wdata,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    modport slave (
        input  req,
        input  addr,
        input  we,
        input  be,
        input  wdata,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface

// File: hw/mem_sys_top.sv
`timescale 1ns/1ps

module mem_sys_top (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,

    // instruction port, read only
    input  logic                                 instr_req_i,
    input  logic [mem_sys_pkg::BUS_DATA_WIDTH-1:0] instr_addr_i,
    output logic                                 instr_gnt_o,
    output logic                                 instr_rvalid_o,
    output logic [mem_sys_pkg::BUS_DATA_WIDTH-1:0] instr_rdata_o,

    // data port
    input  logic                                 data_req_i,
    input  logic [mem_sys_pkg::BUS_DATA_WIDTH-1:0] data_addr_i,
    input  logic                                 data_we_i,
    input  logic [mem_sys_pkg::BUS_BE_WIDTH-1:0]   data_be_i,
    input  logic [mem_sys_pkg::BUS_DATA_WIDTH-1:0] data_wdata_i,
    output logic                                 data_gnt_o,
    output logic                                 data_rvalid_o,
    output logic [mem_sys_pkg::BUS_DATA_WIDTH-1:0] data_rdata_o,

    // interrupt acknowledge from the core
    input  logic                                 irq_ack_i,
    input  logic [mem_sys_pkg::IRQ_ID_WIDTH-1:0]   irq_id_i,
    output logic                                 irq_software_o,
    output logic                                 irq_timer_o,

    // pseudo peripheral outputs
    output logic                                 print_valid_o,
    output logic [7:0]                           print_char_o,
    output logic                                 tests_passed_o,
    output logic                                 tests_failed_o,
    output logic                                 exit_valid_o,
    output logic [mem_sys_pkg::BUS_DATA_WIDTH-1:0] exit_value_o
);

    obi_if instr_bus ();
    obi_if data_bus ();
    obi_if ram_bus ();
    obi_if periph_bus ();

    // instruction fetches never write, all lanes enabled
    assign instr_bus.req   = instr_req_i;
    assign instr_bus.addr  = instr_addr_i;
    assign instr_bus.we    = 1'b0;
    assign instr_bus.be    = '1;
    assign instr_bus.wdata = '0;

    assign instr_gnt_o    = instr_bus.gnt;
    assign instr_rvalid_o = instr_bus.rvalid;
    assign instr_rdata_o  = instr_bus.rdata;

    assign data_bus.req   = data_req_i;
    assign data_bus.addr  = data_addr_i;
    assign data_bus.we    = data_we_i;
    assign data_bus.be    = data_be_i;
    assign data_bus.wdata = data_wdata_i;

    assign data_gnt_o    = data_bus.gnt;
    assign data_rvalid_o = data_bus.rvalid;
    assign data_rdata_o  = data_bus.rdata;

    // data port split between ram and peripherals
    mm_ram_decoder decoder_i (
        .clk_i      ( clk_i      ),
        .arst_n_i   ( arst_n_i   ),
        .data_bus   ( data_bus   ),
        .ram_bus    ( ram_bus    ),
        .periph_bus ( periph_bus )
    );

    dp_ram ram_i (
        .clk_i     ( clk_i     ),
        .arst_n_i  ( arst_n_i  ),
        .instr_bus ( instr_bus ),
        .ram_bus   ( ram_bus   )
    );

    mm_periph periph_i (
        .clk_i          ( clk_i          ),
        .arst_n_i       ( arst_n_i       ),
        .periph_bus     ( periph_bus     ),
        .irq_ack_i      ( irq_ack_i      ),
        .irq_id_i       ( irq_id_i       ),
        .irq_software_o ( irq_software_o ),
        .irq_timer_o    ( irq_timer_o    ),
        .print_valid_o  ( print_valid_o  ),
        .print_char_o   ( print_char_o   ),
        .tests_passed_o ( tests_passed_o ),
        .tests_failed_o ( tests_failed_o ),
        .exit_valid_o   ( exit_valid_o   ),
        .exit_value_o   ( exit_value_o   )
    );

endmodule

// File: hw/mm_ram/dp_ram.sv
`timescale 1ns/1ps

module dp_ram (
    input  logic clk_i,
    input  logic arst_n_i,
    obi_if.slave instr_bus,
    obi_if.slave ram_bus
);

    import mem_sys_pkg::*;

    // word-organized, each word split into byte lanes
    logic [BUS_BE_WIDTH-1:0][7:0] mem [RAM_WORDS];

    logic [RAM_ADDR_WIDTH-3:0] instr_idx;
    logic [RAM_ADDR_WIDTH-3:0] ram_idx;
    logic                      instr_rvalid_q;
    logic                      ram_rvalid_q;

    assign instr_idx = instr_bus.addr[RAM_ADDR_WIDTH-1:2];
    assign ram_idx   = ram_bus.addr[RAM_ADDR_WIDTH-1:2];

    // no wait states on either port
    assign instr_bus.gnt = instr_bus.req;
    assign ram_bus.gnt   = ram_bus.req;

    // reads see the array before this edge's write, so same-cycle reads get old data
    always_ff @(posedge clk_i) begin
        if (instr_bus.req) begin
            instr_bus.rdata <= mem[instr_idx];
        end
        if (ram_bus.req) begin
            ram_bus.rdata <= mem[ram_idx];
            if (ram_bus.we) begin
                for (int i = 0; i < BUS_BE_WIDTH; i++) begin
                    if (ram_bus.be[i]) begin
                        mem[ram_idx][i] <= ram_bus.wdata[8*i +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            instr_rvalid_q <= 1'b0;
            ram_rvalid_q   <= 1'b0;
        end else begin
            instr_rvalid_q <= instr_bus.req;
            ram_rvalid_q   <= ram_bus.req;
        end
    end

    assign instr_bus.rvalid = instr_rvalid_q;
    assign ram_bus.rvalid   = ram_rvalid_q;

    a_instr_no_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        instr_bus.req |-> !instr_bus.we);

    a_word_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (!instr_bus.req || instr_bus.addr[1:0] == 2'b00) &&
        (!ram_bus.req || ram_bus.addr[1:0] == 2'b00));

endmodule

// File: hw/mm_ram/mm_periph.sv
`timescale 1ns/1ps

module mm_periph (
    input  logic                                   clk_i,
    input  logic                                   arst_n_i,
    obi_if.slave                                   periph_bus,

    input  logic                                   irq_ack_i,
    input  logic [mem_sys_pkg::IRQ_ID_WIDTH-1:0]   irq_id_i,
    output logic                                   irq_software_o,
    output logic                                   irq_timer_o,

    output logic                                   print_valid_o,
    output logic [7:0]                             print_char_o,
    output logic                                   tests_passed_o,
    output logic                                   tests_failed_o,
    output logic                                   exit_valid_o,
    output logic [mem_sys_pkg::BUS_DATA_WIDTH-1:0] exit_value_o
);

    import mem_sys_pkg::*;

    logic                      wr_en;
    logic                      timer_hit;
    logic                      ack_timer;
    logic                      ack_sw;
    logic [BUS_DATA_WIDTH-1:0] timer_q;
    logic [BUS_DATA_WIDTH-1:0] cmp_q;
    logic                      irq_timer_q;
    logic                      irq_sw_q;
    logic                      rvalid_q;
    logic                      print_valid_q;
    logic                      passed_q;
    logic                      failed_q;
    logic                      exit_valid_q;

    assign periph_bus.gnt = periph_bus.req;
    assign wr_en          = periph_bus.req && periph_bus.we;

    // a compare value of zero keeps the timer stopped
    assign timer_hit = (cmp_q != '0) && (timer_q == cmp_q);
    assign ack_timer = irq_ack_i && (irq_id_i == IRQ_ID_TIMER);
    assign ack_sw    = irq_ack_i && (irq_id_i == IRQ_ID_SW);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            timer_q       <= '0;
            cmp_q         <= '0;
            irq_timer_q   <= 1'b0;
            irq_sw_q      <= 1'b0;
            rvalid_q      <= 1'b0;
            print_valid_q <= 1'b0;
            passed_q      <= 1'b0;
            failed_q      <= 1'b0;
            exit_valid_q  <= 1'b0;
        end else begin
            rvalid_q      <= periph_bus.req;
            print_valid_q <= wr_en && (periph_bus.addr == PRINT_ADDR);

            // bus write to the counter wins over counting
            if (wr_en && periph_bus.addr == TIMER_VALUE_ADDR) begin
                timer_q <= periph_bus.wdata;
            end else if (cmp_q != '0) begin
                timer_q <= timer_q + 1'b1;
            end
            if (wr_en && periph_bus.addr == TIMER_CMP_ADDR) begin
                cmp_q <= periph_bus.wdata;
            end

            // acknowledge takes priority over a new event
            if (ack_timer) begin
                irq_timer_q <= 1'b0;
            end else if (timer_hit) begin
                irq_timer_q <= 1'b1;
            end
            if (ack_sw) begin
                irq_sw_q <= 1'b0;
            end else if (wr_en && periph_bus.addr == SW_IRQ_ADDR) begin
                irq_sw_q <= periph_bus.wdata[0];
            end

            // test status is sticky until reset
            if (wr_en && periph_bus.addr == TEST_STATUS_ADDR) begin
                if (periph_bus.wdata == PASS_MAGIC) begin
                    passed_q <= 1'b1;
                end else begin
                    failed_q <= 1'b1;
                end
            end
            if (wr_en && periph_bus.addr == EXIT_ADDR) begin
                exit_valid_q <= 1'b1;
            end
        end
    end

    // payload and read data
    always_ff @(posedge clk_i) begin
        if (wr_en && periph_bus.addr == PRINT_ADDR) begin
            print_char_o <= periph_bus.wdata[7:0];
        end
        if (wr_en && periph_bus.addr == EXIT_ADDR) begin
            exit_value_o <= periph_bus.wdata;
        end
        case (periph_bus.addr)
            TIMER_VALUE_ADDR: periph_bus.rdata <= timer_q;
            TIMER_CMP_ADDR:   periph_bus.rdata <= cmp_q;
            SW_IRQ_ADDR:      periph_bus.rdata <= {{(BUS_DATA_WIDTH-1){1'b0}}, irq_sw_q};
            default:          periph_bus.rdata <= '0;
        endcase
    end

    assign periph_bus.rvalid = rvalid_q;
    assign irq_timer_o       = irq_timer_q;
    assign irq_software_o    = irq_sw_q;
    assign print_valid_o     = print_valid_q;
    assign tests_passed_o    = passed_q;
    assign tests_failed_o    = failed_q;
    assign exit_valid_o      = exit_valid_q;

    // the core only acknowledges what it was told is pending
    a_ack_pending: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        irq_ack_i |-> (ack_timer && irq_timer_q) || (ack_sw && irq_sw_q));

    a_pass_xor_fail: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(passed_q && failed_q));

endmodule

// File: hw/mm_ram/mm_ram_decoder.sv
`timescale 1ns/1ps

module mm_ram_decoder (
    input  logic  clk_i,
    input  logic  arst_n_i,
    obi_if.slave  data_bus,
    obi_if.master ram_bus,
    obi_if.master periph_bus
);

    import mem_sys_pkg::*;

    typedef enum logic [1:0] {
        TGT_NONE,
        TGT_RAM,
        TGT_PERIPH
    } tgt_e;

    logic sel_ram;
    logic sel_periph;
    tgt_e tgt_d;
    tgt_e tgt_q;
    logic none_rvalid_q;

    // address map decode
    assign sel_ram    = (data_bus.addr[BUS_DATA_WIDTH-1:RAM_ADDR_WIDTH] == '0);
    assign sel_periph = (data_bus.addr >= PERIPH_BASE);

    always_comb begin
        if (sel_ram) begin
            tgt_d = TGT_RAM;
        end else if (sel_periph) begin
            tgt_d = TGT_PERIPH;
        end else begin
            tgt_d = TGT_NONE;
        end
    end

    // only the selected target sees the request
    assign ram_bus.req    = data_bus.req && (tgt_d == TGT_RAM);
    assign ram_bus.addr   = data_bus.addr;
    assign ram_bus.we     = data_bus.we;
    assign ram_bus.be     = data_bus.be;
    assign ram_bus.wdata  = data_bus.wdata;

    assign periph_bus.req   = data_bus.req && (tgt_d == TGT_PERIPH);
    assign periph_bus.addr  = data_bus.addr;
    assign periph_bus.we    = data_bus.we;
    assign periph_bus.be    = data_bus.be;
    assign periph_bus.wdata = data_bus.wdata;

    // unmapped accesses are granted here, writes vanish
    always_comb begin
        case (tgt_d)
            TGT_RAM:    data_bus.gnt = ram_bus.gnt;
            TGT_PERIPH: data_bus.gnt = periph_bus.gnt;
            default:    data_bus.gnt = data_bus.req;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tgt_q         <= TGT_NONE;
            none_rvalid_q <= 1'b0;
        end else begin
            none_rvalid_q <= data_bus.req && data_bus.gnt && (tgt_d == TGT_NONE);
            if (data_bus.req && data_bus.gnt) begin
                tgt_q <= tgt_d;
            end
        end
    end

    // response comes from whoever was granted last cycle
    always_comb begin
        case (tgt_q)
            TGT_RAM: begin
                data_bus.rvalid = ram_bus.rvalid;
                data_bus.rdata  = ram_bus.rdata;
            end
            TGT_PERIPH: begin
                data_bus.rvalid = periph_bus.rvalid;
                data_bus.rdata  = periph_bus.rdata;
            end
            default: begin
                data_bus.rvalid = none_rvalid_q;
                data_bus.rdata  = '0;
            end
        endcase
    end

    a_one_target: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        data_bus.req |-> !(sel_ram && sel_periph));

    a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        data_bus.rvalid |-> $past(data_bus.req && data_bus.gnt));

endmodule

// File: sources.f
+incdir+verification
common/mem_sys_pkg.sv
common/obi_if.sv
hw/mm_ram/mm_ram_decoder.sv
hw/mm_ram/dp_ram.sv
hw/mm_ram/mm_periph.sv
hw/mem_sys_top.sv
verification/tb_mem_sys.sv

// File: verification/tb_mem_sys_model.svh
`ifndef TB_MEM_SYS_MODEL_SVH
`define TB_MEM_SYS_MODEL_SVH

// byte-wide reference copy of the ram, byte address indexed
logic [7:0] ram_model [0:(2**RAM_ADDR_WIDTH)-1];

function automatic logic in_ram(input logic [31:0] addr);
    return addr[31:RAM_ADDR_WIDTH] == '0;
endfunction

// little endian, lowest address in the low byte
function automatic logic [31:0] expected_word(input logic [31:0] addr);
    logic [RAM_ADDR_WIDTH-1:0] base;
    base = {addr[RAM_ADDR_WIDTH-1:2], 2'b00};
    return {ram_model[base + 3], ram_model[base + 2], ram_model[base + 1], ram_model[base]};
endfunction

task automatic update_model(input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata);
    logic [RAM_ADDR_WIDTH-1:0] base;
    base = {addr[RAM_ADDR_WIDTH-1:2], 2'b00};
    for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
            ram_model[base + i] = wdata[8*i +: 8];
        end
    end
endtask

task automatic data_write(input logic [31:0] addr, input logic [3:0] be,
                          input logic [31:0] wdata);
    @(posedge clk_i);
    data_req_i   <= 1'b1;
    data_addr_i  <= addr;
    data_we_i    <= 1'b1;
    data_be_i    <= be;
    data_wdata_i <= wdata;
    @(negedge clk_i);
    check_bit("data_gnt_o", 1'b1, data_gnt_o);
    @(posedge clk_i);
    data_req_i <= 1'b0;
    data_we_i  <= 1'b0;
    if (in_ram(addr)) begin
        update_model(addr, be, wdata);
    end
    @(negedge clk_i);
    check_bit("data_rvalid_o", 1'b1, data_rvalid_o);
endtask

task automatic data_read(input logic [31:0] addr, output logic [31:0] got);
    @(posedge clk_i);
    data_req_i  <= 1'b1;
    data_addr_i <= addr;
    data_we_i   <= 1'b0;
    data_be_i   <= 4'hF;
    @(negedge clk_i);
    check_bit("data_gnt_o", 1'b1, data_gnt_o);
    @(posedge clk_i);
    data_req_i <= 1'b0;
    @(negedge clk_i);
    check_bit("data_rvalid_o", 1'b1, data_rvalid_o);
    got = data_rdata_o;
    if (in_ram(addr)) begin
        check_word("data_rdata_o", expected_word(addr), got);
    end
endtask

task automatic instr_read(input logic [31:0] addr);
    @(posedge clk_i);
    instr_req_i  <= 1'b1;
    instr_addr_i <= addr;
    @(negedge clk_i);
    check_bit("instr_gnt_o", 1'b1, instr_gnt_o);
    @(posedge clk_i);
    instr_req_i <= 1'b0;
    @(negedge clk_i);
    check_bit("instr_rvalid_o", 1'b1, instr_rvalid_o);
    check_word("instr_rdata_o", expected_word(addr), instr_rdata_o);
endtask

// fetch and data write granted on the same edge, the fetch sees old contents
task automatic fetch_during_write(input logic [31:0] iaddr, input logic [31:0] waddr,
                                  input logic [3:0] be, input logic [31:0] wdata);
    logic [31:0] exp;
    exp = expected_word(iaddr);
    @(posedge clk_i);
    instr_req_i  <= 1'b1;
    instr_addr_i <= iaddr;
    data_req_i   <= 1'b1;
    data_addr_i  <= waddr;
    data_we_i    <= 1'b1;
    data_be_i    <= be;
    data_wdata_i <= wdata;
    @(negedge clk_i);
    check_bit("instr_gnt_o", 1'b1, instr_gnt_o);
    check_bit("data_gnt_o", 1'b1, data_gnt_o);
    @(posedge clk_i);
    instr_req_i <= 1'b0;
    data_req_i  <= 1'b0;
    data_we_i   <= 1'b0;
    update_model(waddr, be, wdata);
    @(negedge clk_i);
    check_bit("instr_rvalid_o", 1'b1, instr_rvalid_o);
    check_bit("data_rvalid_o", 1'b1, data_rvalid_o);
    check_word("instr_rdata_o", exp, instr_rdata_o);
endtask

`endif

// File: verification/tb_mem_sys.sv
`timescale 1ns/1ps

module tb_mem_sys;

    import mem_sys_pkg::*;

    localparam int unsigned N_FILL    = 256;
    localparam int unsigned N_RANDOM  = 300;
    localparam int unsigned N_OVERLAP = 100;
    localparam int unsigned N_FETCH   = 20;
    localparam int unsigned N_PRINT   = 16;
    localparam int unsigned N_MISC    = 8;
    localparam int unsigned MAX_CMP   = 60;
    // each overlapped fetch is an instruction read plus a data write
    localparam int unsigned TOTAL_OPS = N_FILL + 2 * N_RANDOM + 2 * N_OVERLAP + N_FETCH
                                      + N_PRINT + N_MISC;
    localparam int unsigned CYCLE_LIMIT = 4 * TOTAL_OPS + MAX_CMP + 200;

    logic        clk_i;
    logic        arst_n_i;
    logic        instr_req_i;
    logic [31:0] instr_addr_i;
    logic        instr_gnt_o;
    logic        instr_rvalid_o;
    logic [31:0] instr_rdata_o;
    logic        data_req_i;
    logic [31:0] data_addr_i;
    logic        data_we_i;
    logic [3:0]  data_be_i;
    logic [31:0] data_wdata_i;
    logic        data_gnt_o;
    logic        data_rvalid_o;
    logic [31:0] data_rdata_o;
    logic        irq_ack_i;
    logic [4:0]  irq_id_i;
    logic        irq_software_o;
    logic        irq_timer_o;
    logic        print_valid_o;
    logic [7:0]  print_char_o;
    logic        tests_passed_o;
    logic        tests_failed_o;
    logic        exit_valid_o;
    logic [31:0] exit_value_o;

    logic [31:0] lfsr_state;
    int unsigned value_errors;
    int unsigned timeouts;
    int unsigned cycle_count;

    mem_sys_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // galois form, shifts right, feedback from bit 0
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] val;
        val = '0;
        for (int unsigned i = 0; i < n; i++) begin
            val        = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return val;
    endfunction

    function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic got);
        assert (got === exp) else begin
            $display("[FAIL] %s expected %h got %h", name, exp, got);
            value_errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
        assert (got === exp) else begin
            $display("[FAIL] %s expected %h got %h", name, exp, got);
            value_errors++;
        end
    endtask

    task automatic ack_irq(input logic [4:0] id);
        @(posedge clk_i);
        irq_ack_i <= 1'b1;
        irq_id_i  <= id;
        @(posedge clk_i);
        irq_ack_i <= 1'b0;
        @(negedge clk_i);
    endtask

    task automatic report_counts();
        $display("errors: %0d wrong values, %0d timeouts", value_errors, timeouts);
    endtask

    `include "tb_mem_sys_model.svh"

    initial begin
        logic [31:0] addr;
        logic [31:0] waddr;
        logic [31:0] wdata;
        logic [31:0] got;
        logic [31:0] r;
        logic [31:0] cmp_val;
        logic [3:0]  be;
        int unsigned waited;
        logic [31:0] addr_q[$];

        arst_n_i     = 1'b0;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        data_req_i   = 1'b0;
        data_addr_i  = '0;
        data_we_i    = 1'b0;
        data_be_i    = '0;
        data_wdata_i = '0;
        irq_ack_i    = 1'b0;
        irq_id_i     = '0;
        lfsr_state   = 32'd9;
        value_errors = 0;
        timeouts     = 0;

        repeat (10) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(negedge clk_i);
        check_bit("instr_rvalid_o", 1'b0, instr_rvalid_o);
        check_bit("data_rvalid_o", 1'b0, data_rvalid_o);
        check_bit("print_valid_o", 1'b0, print_valid_o);
        check_bit("tests_passed_o", 1'b0, tests_passed_o);
        check_bit("tests_failed_o", 1'b0, tests_failed_o);
        check_bit("exit_valid_o", 1'b0, exit_valid_o);
        check_bit("irq_software_o", 1'b0, irq_software_o);
        check_bit("irq_timer_o", 1'b0, irq_timer_o);

        // known contents in the low ram window first
        for (int unsigned i = 0; i < N_FILL; i++) begin
            addr = i * 4;
            data_write(addr, 4'hF, fill_pattern(addr));
        end

        // random byte-enabled writes, then read everything back
        for (int unsigned i = 0; i < N_RANDOM; i++) begin
            addr  = rand_bits(8) << 2;
            r     = rand_bits(4);
            be    = r[3:0];
            wdata = rand_bits(32);
            data_write(addr, be, wdata);
            addr_q.push_back(addr);
        end
        foreach (addr_q[i]) begin
            data_read(addr_q[i], got);
        end

        // fetches racing data writes, half of them to the same word
        for (int unsigned i = 0; i < N_OVERLAP; i++) begin
            addr = rand_bits(8) << 2;
            r    = rand_bits(1);
            if (r[0]) begin
                waddr = addr;
            end else begin
                waddr = rand_bits(8) << 2;
            end
            r     = rand_bits(4);
            be    = r[3:0];
            wdata = rand_bits(32);
            fetch_during_write(addr, waddr, be, wdata);
        end
        for (int unsigned i = 0; i < N_FETCH; i++) begin
            instr_read(rand_bits(8) << 2);
        end

        for (int unsigned i = 0; i < N_PRINT; i++) begin
            wdata = rand_bits(32);
            data_write(PRINT_ADDR, 4'hF, wdata);
            check_bit("print_valid_o", 1'b1, print_valid_o);
            check_word("print_char_o", {24'h0, wdata[7:0]}, {24'h0, print_char_o});
            @(negedge clk_i);
            check_bit("print_valid_o", 1'b0, print_valid_o);
        end

        r       = rand_bits(6);
        cmp_val = 32'd5 + (r % 32'd56);
        data_write(TIMER_CMP_ADDR, 4'hF, cmp_val);
        waited = 0;
        while (irq_timer_o !== 1'b1 && waited < cmp_val + 5) begin
            @(negedge clk_i);
            waited++;
        end
        check_bit("irq_timer_o", 1'b1, irq_timer_o);
        data_read(TIMER_CMP_ADDR, got);
        check_word("data_rdata_o", cmp_val, got);
        if (irq_timer_o) begin
            ack_irq(IRQ_ID_TIMER);
        end
        check_bit("irq_timer_o", 1'b0, irq_timer_o);

        data_write(SW_IRQ_ADDR, 4'hF, 32'd1);
        check_bit("irq_software_o", 1'b1, irq_software_o);
        data_read(SW_IRQ_ADDR, got);
        check_word("data_rdata_o", 32'd1, got);
        if (irq_software_o) begin
            ack_irq(IRQ_ID_SW);
        end
        check_bit("irq_software_o", 1'b0, irq_software_o);

        // hole between ram and peripherals, then an unused peripheral slot
        data_read(32'h0800_0000, got);
        check_word("data_rdata_o", 32'h0, got);
        data_read(32'h3000_0000, got);
        check_word("data_rdata_o", 32'h0, got);

        wdata = rand_bits(32);
        data_write(EXIT_ADDR, 4'hF, wdata);
        check_bit("exit_valid_o", 1'b1, exit_valid_o);
        check_word("exit_value_o", wdata, exit_value_o);
        data_write(TEST_STATUS_ADDR, 4'hF, PASS_MAGIC);
        check_bit("tests_passed_o", 1'b1, tests_passed_o);
        check_bit("tests_failed_o", 1'b0, tests_failed_o);

        @(posedge clk_i);
        report_counts();
        if (value_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        timeouts++;
        report_counts();
        $display("** FAIL **");
        $finish;
    end

endmodule
